// File: soc_map_pkg.sv
package soc_map_pkg;

    // Bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Memory regions, sized in 32-bit words
    localparam logic [addr_width-1:0] rom_base = 32'h0000_0000;
    localparam int rom_words = 64;
    localparam logic [addr_width-1:0] ram_base = 32'h0000_1000;
    localparam int ram_words = 256;
    localparam logic [addr_width-1:0] rom_limit = rom_base + 32'(rom_words * 4);
    localparam logic [addr_width-1:0] ram_limit = ram_base + 32'(ram_words * 4);

    // ROM fills the low entries, RAM follows it
    localparam int mem_words = rom_words + ram_words;
    localparam int mem_index_width = $clog2(mem_words);
    localparam int rom_index_width = $clog2(rom_words);
    localparam int ram_index_width = $clog2(ram_words);

    // Peripheral registers
    localparam logic [addr_width-1:0] key_addr = 32'h0000_2000;
    localparam logic [addr_width-1:0] uart_addr = 32'h0000_2004;
    localparam logic [addr_width-1:0] tmr_cnt_addr = 32'h0000_2008;
    localparam logic [addr_width-1:0] tmr_cmp_addr = 32'h0000_200C;

    // Field split of the memory view
    localparam int tag_width = 20;
    localparam int index_width = 10;
    localparam logic [tag_width-1:0] ram_tag = ram_base[addr_width-1:addr_width-tag_width];

    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [tag_width-1:0] tag;
            logic [index_width-1:0] index;
            logic [1:0] offset;
        } mem;
    } bus_addr_u;

endpackage

// File: soc_irq_pkg.sv
package soc_irq_pkg;

    // Vector codes seen by the processor
    localparam int vector_width = 4;
    localparam logic [vector_width-1:0] vec_none = 4'd0;
    localparam logic [vector_width-1:0] vec_key = 4'd1;
    localparam logic [vector_width-1:0] vec_timer = 4'd2;

    // Controller either waits or presents one vector
    typedef enum logic {
        irq_idle = 1'b0,
        irq_active = 1'b1
    } irq_state_e;

    // Interval timer counter and compare width
    localparam int timer_width = 32;

endpackage

// File: soc_bus_if.sv
`timescale 1ns/10ps

interface soc_bus_if;
    import soc_map_pkg::*;

    bus_addr_u address;
    logic [data_width-1:0] write_data;
    logic write_enable;
    logic read_enable;

    // One select per slave, at most one high
    logic mem_sel;
    logic key_sel;
    logic uart_sel;
    logic tmr_sel;

    // Registered read words returned by the slaves
    logic [data_width-1:0] mem_rdata;
    logic [data_width-1:0] key_rdata;
    logic [data_width-1:0] tmr_rdata;

    modport decoder (
        output address, write_data, write_enable, read_enable,
        output mem_sel, key_sel, uart_sel, tmr_sel,
        input mem_rdata, key_rdata, tmr_rdata
    );

    modport mem_slave (
        input address, write_data, write_enable, mem_sel,
        output mem_rdata
    );

    modport periph_slave (
        input write_data, write_enable, read_enable, key_sel, uart_sel,
        output key_rdata
    );

    modport timer_slave (
        input address, write_data, write_enable, read_enable, tmr_sel,
        output tmr_rdata
    );

endinterface

// File: bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder (
    soc_bus_if.decoder bus,
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic [soc_map_pkg::addr_width-1:0] bus_address,
    input  logic [soc_map_pkg::data_width-1:0] bus_write_data,
    input  logic bus_write_enable,
    input  logic bus_read_enable,
    output logic [soc_map_pkg::data_width-1:0] bus_read_data
);
    import soc_map_pkg::*;

    logic read_mem_q;
    logic read_key_q;
    logic read_tmr_q;

    assign bus.address.raw = bus_address;
    assign bus.write_data = bus_write_data;
    assign bus.write_enable = bus_write_enable;
    assign bus.read_enable = bus_read_enable;

    // ROM and RAM are ranges, registers are exact words
    assign bus.mem_sel = ((bus_address >= rom_base) && (bus_address < rom_limit)) ||
                         ((bus_address >= ram_base) && (bus_address < ram_limit));
    assign bus.key_sel = (bus_address == key_addr);
    assign bus.uart_sel = (bus_address == uart_addr);
    assign bus.tmr_sel = (bus_address == tmr_cnt_addr) || (bus_address == tmr_cmp_addr);

    // Remember which slave answers the read for the next cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_mem_q <= 1'b0;
            read_key_q <= 1'b0;
            read_tmr_q <= 1'b0;
        end else begin
            read_mem_q <= bus_read_enable && bus.mem_sel;
            read_key_q <= bus_read_enable && bus.key_sel;
            read_tmr_q <= bus_read_enable && bus.tmr_sel;
        end
    end

    // Zero unless a mapped read was taken at the last edge
    assign bus_read_data = read_mem_q ? bus.mem_rdata :
                           read_key_q ? bus.key_rdata :
                           read_tmr_q ? bus.tmr_rdata :
                           '0;

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $onehot0({bus.mem_sel, bus.key_sel, bus.uart_sel, bus.tmr_sel}))
    else $error("more than one bus slave selected");

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable))
    else $error("read and write strobes in the same cycle");

endmodule

// File: unified_memory.sv
`timescale 1ns/10ps

module unified_memory (
    soc_bus_if.mem_slave bus,
    input  logic CLOCK_50
);
    import soc_map_pkg::*;

    logic [data_width-1:0] mem_array [0:mem_words-1];
    logic is_ram;
    logic [mem_index_width-1:0] entry;

    // Start from a clean array, then overlay the boot image
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem_array[i] = '0;
        end
        $readmemh("rom.hex", mem_array, 0);
    end

    // RAM words sit above the ROM words in the array
    assign is_ram = (bus.address.mem.tag == ram_tag);
    assign entry = is_ram ?
        mem_index_width'(rom_words) +
            mem_index_width'(bus.address.mem.index[ram_index_width-1:0]) :
        mem_index_width'(bus.address.mem.index[rom_index_width-1:0]);

    // Read returns the word as it was before a write at the same edge
    always @(posedge CLOCK_50) begin
        if (bus.mem_sel) begin
            bus.mem_rdata <= mem_array[entry];
        end
        // ROM range is read only
        if (bus.mem_sel && bus.write_enable && is_ram) begin
            mem_array[entry] <= bus.write_data;
        end
    end

endmodule

// File: keyboard_console_regs.sv
`timescale 1ns/10ps

module keyboard_console_regs (
    soc_bus_if.periph_slave bus,
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic key_valid,
    input  logic [7:0] key_code,
    output logic key_request,
    output logic uart_valid,
    output logic [7:0] uart_data
);
    logic [7:0] key_q;
    logic uart_write;
    logic uart_write_q;

    // A zero code is not a key
    assign key_request = key_valid && (key_code != 8'd0);

    assign uart_write = bus.uart_sel && bus.write_enable;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_q <= 8'd0;
            uart_write_q <= 1'b0;
            uart_valid <= 1'b0;
        end else begin
            if (key_request) begin
                key_q <= key_code;
            end
            uart_write_q <= uart_write;
            // Only the first write of a back-to-back run is sent
            uart_valid <= uart_write && !uart_write_q;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (uart_write && !uart_write_q) begin
            uart_data <= bus.write_data[7:0];
        end
        if (bus.key_sel && bus.read_enable) begin
            bus.key_rdata <= {24'd0, key_q};
        end
    end

endmodule

// File: interval_timer.sv
`timescale 1ns/10ps

module interval_timer (
    soc_bus_if.timer_slave bus,
    input  logic CLOCK_50,
    input  logic KEY0,
    output logic timer_request
);
    import soc_map_pkg::*;
    import soc_irq_pkg::*;

    logic [timer_width-1:0] counter;
    logic [timer_width-1:0] compare;
    logic write_cnt;
    logic write_cmp;

    assign write_cnt = bus.tmr_sel && bus.write_enable && (bus.address.raw == tmr_cnt_addr);
    assign write_cmp = bus.tmr_sel && bus.write_enable && (bus.address.raw == tmr_cmp_addr);

    // Zero compare keeps the timer quiet
    assign timer_request = (compare != '0) && (counter == compare);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            counter <= '0;
            compare <= '0;
        end else begin
            // Bus load overrides the increment
            if (write_cnt) begin
                counter <= bus.write_data;
            end else begin
                counter <= counter + 1'b1;
            end
            if (write_cmp) begin
                compare <= bus.write_data;
            end
        end
    end

    // Values seen before this edge's update
    always_ff @(posedge CLOCK_50) begin
        if (bus.tmr_sel && bus.read_enable) begin
            if (bus.address.raw == tmr_cmp_addr) begin
                bus.tmr_rdata <= compare;
            end else begin
                bus.tmr_rdata <= counter;
            end
        end
    end

endmodule

// File: irq_controller.sv
`timescale 1ns/10ps

module irq_controller (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic key_request,
    input  logic timer_request,
    input  logic interrupt_ack,
    output logic [soc_irq_pkg::vector_width-1:0] interrupt_vector
);
    import soc_irq_pkg::*;

    irq_state_e state;
    logic key_pending;
    logic timer_pending;
    logic ack_key;
    logic ack_timer;

    // Ack clears only the source being served
    assign ack_key = (state == irq_active) && interrupt_ack && (interrupt_vector == vec_key);
    assign ack_timer = (state == irq_active) && interrupt_ack && (interrupt_vector == vec_timer);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= irq_idle;
            interrupt_vector <= vec_none;
            key_pending <= 1'b0;
            timer_pending <= 1'b0;
        end else begin
            // New request wins over a clear at the same edge
            key_pending <= (key_pending && !ack_key) || key_request;
            timer_pending <= (timer_pending && !ack_timer) || timer_request;

            case (state)
                irq_idle: begin
                    // Keyboard first
                    if (key_pending) begin
                        state <= irq_active;
                        interrupt_vector <= vec_key;
                    end else if (timer_pending) begin
                        state <= irq_active;
                        interrupt_vector <= vec_timer;
                    end
                end
                irq_active: begin
                    if (interrupt_ack) begin
                        state <= irq_idle;
                        interrupt_vector <= vec_none;
                    end
                end
                default: begin
                    state <= irq_idle;
                    interrupt_vector <= vec_none;
                end
            endcase
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (state == irq_idle) |-> (interrupt_vector == vec_none))
    else $error("interrupt vector presented while controller idle");

endmodule

// File: soc_top.sv
`timescale 1ns/10ps

module soc_top (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic [soc_map_pkg::addr_width-1:0] bus_address,
    input  logic [soc_map_pkg::data_width-1:0] bus_write_data,
    input  logic bus_write_enable,
    input  logic bus_read_enable,
    output logic [soc_map_pkg::data_width-1:0] bus_read_data,
    input  logic key_valid,
    input  logic [7:0] key_code,
    output logic uart_valid,
    output logic [7:0] uart_data,
    output logic [soc_irq_pkg::vector_width-1:0] interrupt_vector,
    input  logic interrupt_ack
);
    soc_bus_if bus ();

    logic key_request;
    logic timer_request;

    bus_decoder bus_decoder_inst (
        .bus              (bus.decoder),
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    unified_memory unified_memory_inst (
        .bus      (bus.mem_slave),
        .CLOCK_50 (CLOCK_50)
    );

    keyboard_console_regs keyboard_console_regs_inst (
        .bus         (bus.periph_slave),
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .key_request (key_request),
        .uart_valid  (uart_valid),
        .uart_data   (uart_data)
    );

    interval_timer interval_timer_inst (
        .bus           (bus.timer_slave),
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .timer_request (timer_request)
    );

    irq_controller irq_controller_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_request      (key_request),
        .timer_request    (timer_request),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);
    // 100 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // Reset low for four cycles, released on a falling edge
    initial begin
        KEY0 = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

// File: soc_tb.sv
`timescale 1ns/10ps

module soc_tb;
    import soc_map_pkg::*;
    import soc_irq_pkg::*;

    // Cycle budget per test
    localparam int reset_cycles = 4;
    localparam int mem_rw_cycles = 400 + rom_words;
    localparam int bus_idle_cycles = 200;
    localparam int console_cycles = 100 * 6;
    localparam int keyboard_cycles = 20 * 9;
    localparam int timer_cycles = 10 * 43;
    localparam int priority_cycles = 5 * 16;
    localparam int cycle_limit = reset_cycles + mem_rw_cycles + bus_idle_cycles +
        console_cycles + keyboard_cycles + timer_cycles + priority_cycles + 50;

    logic CLOCK_50;
    logic KEY0;
    logic [addr_width-1:0] bus_address;
    logic [data_width-1:0] bus_write_data;
    logic bus_write_enable;
    logic bus_read_enable;
    logic [data_width-1:0] bus_read_data;
    logic key_valid;
    logic [7:0] key_code;
    logic uart_valid;
    logic [7:0] uart_data;
    logic [vector_width-1:0] interrupt_vector;
    logic interrupt_ack;

    // Reference model state
    logic [data_width-1:0] mem_model [0:mem_words-1];
    logic [7:0] m_key;
    logic [timer_width-1:0] m_counter;
    logic [timer_width-1:0] m_compare;
    logic m_key_pend;
    logic m_tmr_pend;
    irq_state_e m_state;
    logic [vector_width-1:0] m_vector;
    logic m_uart_prev;
    logic [data_width-1:0] exp_rdata;
    logic exp_uart_valid;
    logic [7:0] exp_uart_data;

    logic [31:0] rng_state;
    logic [31:0] tmr_base;
    string test_name;
    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int cycle_count;

    tb_clock_gen tb_clock_gen_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    soc_top soc_top_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_valid        (key_valid),
        .key_code         (key_code),
        .uart_valid       (uart_valid),
        .uart_data        (uart_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic in_rom(input logic [31:0] addr);
        return (addr >= rom_base) && (addr < rom_base + rom_words * 4);
    endfunction

    function automatic logic in_ram(input logic [31:0] addr);
        return (addr >= ram_base) && (addr < ram_base + ram_words * 4);
    endfunction

    function automatic logic [31:0] unmapped_addr(input logic [1:0] pick);
        case (pick)
            2'd0: return 32'h0000_0800;
            2'd1: return ram_base + ram_words * 4;
            2'd2: return 32'h0000_2010;
            default: return 32'hFFFF_FFFC;
        endcase
    endfunction

    // Small RAM window so reads often hit earlier writes
    function logic [31:0] ram_addr();
        return ram_base + ((rand_word() % 32) << 2);
    endfunction

    function logic [31:0] rom_addr();
        return rom_base + ((rand_word() % rom_words) << 2);
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        assert (actual === expected) else begin
            $display("MISMATCH %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input logic ok, input string msg);
        test_checks++;
        assert (ok) else begin
            $display("%s: %s", test_name, msg);
            test_errors++;
        end
    endtask

    // One rising edge of the model, inputs as driven for that edge
    task automatic model_edge(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic we, input logic re, input logic kv,
                              input logic [7:0] kc, input logic ack);
        logic key_req;
        logic tmr_req;
        logic uart_wr;
        logic clear_key;
        logic clear_tmr;
        key_req = kv && (kc != 8'd0);
        tmr_req = (m_compare != '0) && (m_counter == m_compare);
        uart_wr = we && (addr == uart_addr);
        clear_key = (m_state == irq_active) && ack && (m_vector == vec_key);
        clear_tmr = (m_state == irq_active) && ack && (m_vector == vec_timer);

        // Old values are returned on a read
        exp_rdata = '0;
        if (re) begin
            if (in_rom(addr)) begin
                exp_rdata = mem_model[(addr - rom_base) >> 2];
            end else if (in_ram(addr)) begin
                exp_rdata = mem_model[rom_words + ((addr - ram_base) >> 2)];
            end else if (addr == key_addr) begin
                exp_rdata = {24'd0, m_key};
            end else if (addr == tmr_cnt_addr) begin
                exp_rdata = m_counter;
            end else if (addr == tmr_cmp_addr) begin
                exp_rdata = m_compare;
            end
        end
        if (we && in_ram(addr)) begin
            mem_model[rom_words + ((addr - ram_base) >> 2)] = wdata;
        end

        exp_uart_valid = uart_wr && !m_uart_prev;
        if (exp_uart_valid) begin
            exp_uart_data = wdata[7:0];
        end
        m_uart_prev = uart_wr;

        if (key_req) begin
            m_key = kc;
        end
        if (we && (addr == tmr_cnt_addr)) begin
            m_counter = wdata;
        end else begin
            m_counter = m_counter + 1;
        end
        if (we && (addr == tmr_cmp_addr)) begin
            m_compare = wdata;
        end

        // Controller acts on the pending flags seen before this edge
        if (m_state == irq_active) begin
            if (ack) begin
                m_state = irq_idle;
                m_vector = vec_none;
            end
        end else if (m_key_pend) begin
            m_state = irq_active;
            m_vector = vec_key;
        end else if (m_tmr_pend) begin
            m_state = irq_active;
            m_vector = vec_timer;
        end
        m_key_pend = (m_key_pend && !clear_key) || key_req;
        m_tmr_pend = (m_tmr_pend && !clear_tmr) || tmr_req;
    endtask

    // Drive on the falling edge, check after the next rising edge
    task automatic bus_step(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic we, input logic re, input logic kv,
                            input logic [7:0] kc, input logic ack);
        bus_address = addr;
        bus_write_data = wdata;
        bus_write_enable = we;
        bus_read_enable = re;
        key_valid = kv;
        key_code = kc;
        interrupt_ack = ack;
        model_edge(addr, wdata, we, re, kv, kc, ack);
        @(negedge CLOCK_50);
        check_value("read data", exp_rdata, bus_read_data);
        check_value("uart_valid", exp_uart_valid, uart_valid);
        if (exp_uart_valid) begin
            check_value("uart_data", exp_uart_data, uart_data);
        end
        check_value("interrupt_vector", m_vector, interrupt_vector);
    endtask

    task automatic idle_step();
        bus_step('0, '0, 1'b0, 1'b0, 1'b0, 8'd0, 1'b0);
    endtask

    task automatic write_step(input logic [31:0] addr, input logic [31:0] data);
        bus_step(addr, data, 1'b1, 1'b0, 1'b0, 8'd0, 1'b0);
    endtask

    task automatic read_step(input logic [31:0] addr);
        bus_step(addr, '0, 1'b0, 1'b1, 1'b0, 8'd0, 1'b0);
    endtask

    task automatic key_step(input logic [7:0] code);
        bus_step('0, '0, 1'b0, 1'b0, 1'b1, code, 1'b0);
    endtask

    task automatic ack_step();
        bus_step('0, '0, 1'b0, 1'b0, 1'b0, 8'd0, 1'b1);
    endtask

    task automatic exercise_memory();
        logic [31:0] r;
        logic [31:0] data;
        start_test("mem_rw");
        for (int i = 0; i < 400; i++) begin
            r = rand_word();
            data = rand_word();
            case (r % 5)
                0, 1: write_step(ram_addr(), data);
                2: read_step(ram_addr());
                3: write_step(rom_addr(), data);
                default: begin
                    if (r[8]) begin
                        read_step(rom_addr());
                    end else begin
                        read_step(unmapped_addr(r[10:9]));
                    end
                end
            endcase
        end
        // Whole ROM against the boot image after the ROM writes
        for (int i = 0; i < rom_words; i++) begin
            read_step(rom_base + i * 4);
        end
        end_test();
    endtask

    task automatic idle_bus_check();
        logic [31:0] r;
        logic [31:0] data;
        start_test("bus_idle");
        for (int i = 0; i < 200; i++) begin
            r = rand_word();
            data = rand_word();
            case (r % 4)
                0: idle_step();
                1: write_step(ram_addr(), data);
                2: write_step(rom_addr(), data);
                default: write_step(unmapped_addr(r[9:8]), data);
            endcase
            check_value("idle read data", 32'd0, bus_read_data);
        end
        end_test();
    endtask

    task automatic console_runs();
        int len;
        int strobes;
        int strobe_at;
        logic [31:0] data;
        logic [7:0] first_byte;
        logic [7:0] seen_byte;
        start_test("console");
        for (int run = 0; run < 100; run++) begin
            len = 1 + rand_word() % 4;
            strobes = 0;
            strobe_at = -1;
            first_byte = 8'd0;
            seen_byte = 8'd0;
            for (int k = 0; k < len; k++) begin
                data = rand_word();
                if (k == 0) begin
                    first_byte = data[7:0];
                end
                write_step(uart_addr, data);
                if (uart_valid) begin
                    strobes++;
                    strobe_at = k;
                    seen_byte = uart_data;
                end
            end
            repeat (2) begin
                idle_step();
                if (uart_valid) begin
                    strobes++;
                end
            end
            check_value("strobes per run", 1, strobes);
            check_value("strobe position", 0, strobe_at);
            check_value("strobe byte", first_byte, seen_byte);
        end
        end_test();
    endtask

    task automatic keyboard_interrupts();
        logic [7:0] code;
        int waited;
        start_test("keyboard_irq");
        for (int i = 0; i < 20; i++) begin
            code = 8'(rand_word());
            if (rand_word() % 4 == 0) begin
                code = 8'd0;
            end
            key_step(code);
            if (code != 8'd0) begin
                waited = 1;
                while ((interrupt_vector !== vec_key) && (waited < 6)) begin
                    idle_step();
                    waited++;
                end
                check_flag(interrupt_vector === vec_key,
                           "keyboard interrupt vector did not appear within 5 cycles");
                check_value("key vector latency", 2, waited);
                read_step(key_addr);
                check_value("key register", {24'd0, code}, bus_read_data);
                ack_step();
                check_value("vector after ack", vec_none, interrupt_vector);
                idle_step();
                check_value("vector after ack", vec_none, interrupt_vector);
            end else begin
                repeat (3) begin
                    idle_step();
                    check_value("zero code vector", vec_none, interrupt_vector);
                end
            end
        end
        end_test();
    endtask

    task automatic timer_matches();
        logic [31:0] cmp;
        logic [31:0] v;
        int d;
        int k;
        start_test("timer_irq");
        for (int i = 0; i < 10; i++) begin
            // Each round sits above the last compare so no stale match occurs
            tmr_base = tmr_base + 64;
            cmp = tmr_base + rand_word() % 16;
            d = 5 + rand_word() % 10;
            v = cmp - d;
            write_step(tmr_cnt_addr, v);
            write_step(tmr_cmp_addr, cmp);
            k = 1;
            while ((interrupt_vector !== vec_timer) && (k < 40)) begin
                read_step(tmr_cnt_addr);
                k++;
                check_value("counter read", v + k - 1, bus_read_data);
            end
            check_flag(interrupt_vector === vec_timer,
                       "timer interrupt vector did not appear within 40 cycles");
            check_value("timer vector latency", d + 2, k);
            ack_step();
            check_value("vector after ack", vec_none, interrupt_vector);
            read_step(tmr_cmp_addr);
            check_value("compare read", cmp, bus_read_data);
            check_value("vector after ack", vec_none, interrupt_vector);
        end
        end_test();
    endtask

    task automatic irq_priority();
        logic [31:0] cmp;
        logic [31:0] v;
        int d;
        start_test("priority");
        for (int i = 0; i < 5; i++) begin
            tmr_base = tmr_base + 64;
            cmp = tmr_base + rand_word() % 16;
            d = 4 + rand_word() % 6;
            v = cmp - d;
            write_step(tmr_cnt_addr, v);
            write_step(tmr_cmp_addr, cmp);
            for (int k = 2; k <= d; k++) begin
                idle_step();
            end
            // Key strobe at the same edge the timer match is taken
            key_step(8'(rand_word()) | 8'h01);
            idle_step();
            check_value("first vector", vec_key, interrupt_vector);
            ack_step();
            check_value("vector after key ack", vec_none, interrupt_vector);
            idle_step();
            check_value("second vector", vec_timer, interrupt_vector);
            ack_step();
            check_value("vector after timer ack", vec_none, interrupt_vector);
            idle_step();
            check_value("vector after timer ack", vec_none, interrupt_vector);
        end
        end_test();
    endtask

    initial begin
        for (cycle_count = 0; cycle_count < cycle_limit; cycle_count++) begin
            @(posedge CLOCK_50);
        end
        $display("Run timed out after %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        bus_address = '0;
        bus_write_data = '0;
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        key_valid = 1'b0;
        key_code = 8'd0;
        interrupt_ack = 1'b0;
        rng_state = 32'h2452d493;
        tmr_base = '0;
        total_checks = 0;
        total_errors = 0;

        // Model starts in the reset state with the same boot image
        for (int i = 0; i < mem_words; i++) begin
            mem_model[i] = '0;
        end
        $readmemh("rom.hex", mem_model, 0);
        m_key = 8'd0;
        m_counter = '0;
        m_compare = '0;
        m_key_pend = 1'b0;
        m_tmr_pend = 1'b0;
        m_state = irq_idle;
        m_vector = vec_none;
        m_uart_prev = 1'b0;
        exp_rdata = '0;
        exp_uart_valid = 1'b0;
        exp_uart_data = 8'd0;

        @(posedge KEY0);
        exercise_memory();
        idle_bus_check();
        console_runs();
        keyboard_interrupts();
        timer_matches();
        irq_priority();

        $display("Total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rom.hex
// One 32-bit word per line, ROM entries 0 to 7
00001137
00000093
0040006f
deadbeef
12345678
a5a55a5a
0000ffff
80000001

// File: all.f
soc_map_pkg.sv
soc_irq_pkg.sv
soc_bus_if.sv
bus_decoder.sv
unified_memory.sv
keyboard_console_regs.sv
interval_timer.sv
irq_controller.sv
soc_top.sv
tb_clock_gen.sv
soc_tb.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - soc_map_pkg.sv
  - soc_irq_pkg.sv
  - soc_bus_if.sv
  - bus_decoder.sv
  - unified_memory.sv
  - keyboard_console_regs.sv
  - interval_timer.sv
  - irq_controller.sv
  - soc_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - soc_tb.sv
